// ==== bpu_cfg_pkg.sv ====
package bpu_cfg_pkg;

    localparam int vaddr_size = 32;
    localparam int ubtb_size = 8;
    localparam int ubtb_idx_w = $clog2(ubtb_size);

    localparam int btb_tag_size = 12;      // tag sits directly above the block offset
    localparam int block_size = 32;        // fetch block in bytes
    localparam int block_off_w = $clog2(block_size);

    localparam int prediction_width = 4;   // slot offset and block size, in halfwords
    localparam int jal_offset = 12;        // stored low target bits of the conditional slot
    localparam int jalr_offset = 20;       // stored low target bits of the tail slot

    localparam int slot_num = 2;
    localparam int cond_cnt_w = $clog2(slot_num + 1);

    localparam logic [7:0] replace_seed = 8'h5a;

endpackage

// ==== btb_types_pkg.sv ====
package btb_types_pkg;

    typedef enum logic [1:0] {
        condition = 2'd0,
        direct    = 2'd1,
        indirect  = 2'd2,
        call      = 2'd3
    } br_type_e;

    // relation of the target's high part to the fetch address high part
    typedef enum logic [1:0] {
        tar_norm = 2'd0,
        tar_ov   = 2'd1,  // high part is one more
        tar_un   = 2'd2   // high part is one less
    } tar_state_e;

endpackage

// ==== ubtb_replace.sv ====
module ubtb_replace (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alloc,
    output logic [bpu_cfg_pkg::ubtb_idx_w-1:0] victim_way
);
    import bpu_cfg_pkg::*;

    logic [7:0] state_q;
    logic       feedback;

    assign feedback = state_q[7] ^ state_q[5] ^ state_q[4] ^ state_q[3]; // maximal length taps

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= replace_seed;
        end else if (alloc) begin
            state_q <= {state_q[6:0], feedback};
        end
    end

    assign victim_way = state_q[ubtb_idx_w-1:0];

endmodule

// ==== btb_target_calc.sv ====
module btb_target_calc #(
    parameter int low_w = bpu_cfg_pkg::jal_offset
) (
    input  logic [bpu_cfg_pkg::vaddr_size-low_w-2:0] pc_high,
    input  logic [low_w-1:0]                         low_target,
    input  btb_types_pkg::tar_state_e                tar_state,
    output logic [bpu_cfg_pkg::vaddr_size-1:0]       target
);
    import bpu_cfg_pkg::*;
    import btb_types_pkg::*;

    localparam int high_w = vaddr_size - low_w - 1;

    logic [high_w-1:0] high_adj;

    always_comb begin
        case (tar_state)
            tar_ov:  high_adj = pc_high + 1'b1;
            tar_un:  high_adj = pc_high - 1'b1;
            default: high_adj = pc_high;
        endcase
    end

    assign target = {high_adj, low_target, 1'b0}; // targets are halfword aligned

endmodule

// ==== ubtb.sv ====
module ubtb (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [bpu_cfg_pkg::vaddr_size-1:0]       pc,
    input  logic                                     update,
    input  logic [bpu_cfg_pkg::vaddr_size-1:0]       upd_start_addr,
    input  logic                                     upd_br_en,
    input  logic [bpu_cfg_pkg::prediction_width-1:0] upd_br_offset,
    input  logic [bpu_cfg_pkg::jal_offset-1:0]       upd_br_target,
    input  btb_types_pkg::tar_state_e                upd_br_tar_state,
    input  logic                                     upd_br_carry,
    input  logic                                     upd_tail_en,
    input  btb_types_pkg::br_type_e                  upd_tail_type,
    input  logic [bpu_cfg_pkg::prediction_width-1:0] upd_tail_offset,
    input  logic [bpu_cfg_pkg::jalr_offset-1:0]      upd_tail_target,
    input  btb_types_pkg::tar_state_e                upd_tail_tar_state,
    input  logic                                     upd_tail_carry,
    input  logic [bpu_cfg_pkg::prediction_width-1:0] upd_fth_size,
    input  logic [bpu_cfg_pkg::slot_num-1:0][1:0]    upd_meta_ctr,
    input  logic [bpu_cfg_pkg::slot_num-1:0]         upd_real_taken,
    output logic                                     lk_hit,
    output logic                                     lk_taken,
    output btb_types_pkg::br_type_e                  lk_br_type,
    output logic [bpu_cfg_pkg::prediction_width-1:0] lk_size,
    output logic [bpu_cfg_pkg::vaddr_size-1:0]       lk_target,
    output logic [bpu_cfg_pkg::cond_cnt_w-1:0]       lk_cond_num,
    output logic [bpu_cfg_pkg::slot_num-1:0]         lk_cond_valid,
    output logic [bpu_cfg_pkg::slot_num-1:0]         lk_pred_taken,
    output logic [bpu_cfg_pkg::slot_num-1:0][1:0]    lk_ctr
);
    import bpu_cfg_pkg::*;
    import btb_types_pkg::*;

    logic [ubtb_size-1:0]          valid_q;
    logic [slot_num-1:0][1:0]      ctr_q [ubtb_size];
    logic [btb_tag_size-1:0]       tag_q [ubtb_size];
    logic                          br_en_q [ubtb_size];
    logic [prediction_width-1:0]   br_offset_q [ubtb_size];
    logic [jal_offset-1:0]         br_target_q [ubtb_size];
    tar_state_e                    br_tar_state_q [ubtb_size];
    logic                          br_carry_q [ubtb_size];
    logic                          tail_en_q [ubtb_size];
    br_type_e                      tail_type_q [ubtb_size];
    logic [prediction_width-1:0]   tail_offset_q [ubtb_size];
    logic [jalr_offset-1:0]        tail_target_q [ubtb_size];
    tar_state_e                    tail_tar_state_q [ubtb_size];
    logic                          tail_carry_q [ubtb_size];
    logic [prediction_width-1:0]   fth_size_q [ubtb_size];

    logic [btb_tag_size-1:0] lk_tag, upd_tag;
    logic [ubtb_size-1:0]    lk_hits, upd_hits;
    logic [ubtb_idx_w-1:0]   hit_way, upd_way, wr_way, victim_way;
    logic                    upd_hit, alloc;
    logic [slot_num-1:0]     is_br, carry, br_takens;
    logic                    cond_taken, uncond_tail, older, tail_first, sel_tail;
    logic [vaddr_size-1:0]   br_target_full, tail_target_full;
    logic [slot_num-1:0][1:0] new_ctr;

    assign lk_tag = pc[block_off_w +: btb_tag_size];
    assign upd_tag = upd_start_addr[block_off_w +: btb_tag_size];

    always_comb begin
        hit_way = '0;
        upd_way = '0;
        for (int i = 0; i < ubtb_size; i++) begin
            lk_hits[i] = valid_q[i] && (tag_q[i] == lk_tag);
            upd_hits[i] = valid_q[i] && (tag_q[i] == upd_tag);
        end
        for (int i = ubtb_size - 1; i >= 0; i--) begin
            if (lk_hits[i]) hit_way = ubtb_idx_w'(i);  // lowest matching way wins
            if (upd_hits[i]) upd_way = ubtb_idx_w'(i);
        end
    end

    assign lk_hit = |lk_hits;
    assign upd_hit = |upd_hits;

    assign is_br = {tail_en_q[hit_way] && (tail_type_q[hit_way] == condition), br_en_q[hit_way]};
    assign carry = {tail_carry_q[hit_way], br_carry_q[hit_way]};
    assign br_takens = is_br & ({ctr_q[hit_way][1][1], ctr_q[hit_way][0][1]} | carry);

    assign cond_taken = |br_takens;
    assign uncond_tail = tail_en_q[hit_way] && (tail_type_q[hit_way] != condition);
    assign older = br_offset_q[hit_way] < tail_offset_q[hit_way];
    assign tail_first = br_takens[1] && !older;
    assign sel_tail = br_takens[1] && (!br_takens[0] || !older);

    btb_target_calc #(.low_w(jal_offset)) i_br_target (
        .pc_high   (pc[vaddr_size-1:jal_offset+1]),
        .low_target(sel_tail ? tail_target_q[hit_way][jal_offset-1:0] : br_target_q[hit_way]),
        .tar_state (sel_tail ? tail_tar_state_q[hit_way] : br_tar_state_q[hit_way]),
        .target    (br_target_full)
    );

    btb_target_calc #(.low_w(jalr_offset)) i_tail_target (
        .pc_high   (pc[vaddr_size-1:jalr_offset+1]),
        .low_target(tail_target_q[hit_way]),
        .tar_state (tail_tar_state_q[hit_way]),
        .target    (tail_target_full)
    );

    always_comb begin
        lk_taken = cond_taken || uncond_tail;   // qualified by lk_hit in the stage register
        lk_br_type = cond_taken ? condition : tail_type_q[hit_way];
        lk_pred_taken = br_takens;
        lk_ctr = ctr_q[hit_way];
        if (!lk_hit) begin
            lk_size = '1;
            lk_target = pc + vaddr_size'(block_size);
            lk_cond_num = '0;
            lk_cond_valid = '0;
        end else begin
            if (cond_taken) begin
                lk_size = sel_tail ? tail_offset_q[hit_way] : br_offset_q[hit_way];
                lk_target = br_target_full;
            end else if (uncond_tail) begin
                lk_size = tail_offset_q[hit_way];
                lk_target = tail_target_full;
            end else begin
                lk_size = fth_size_q[hit_way];
                lk_target = pc + vaddr_size'(fth_size_q[hit_way]);
            end
            lk_cond_num = tail_first ? cond_cnt_w'(1) :
                          cond_cnt_w'(is_br[0]) + cond_cnt_w'(is_br[1]);
            lk_cond_valid = tail_first ? 2'b10 : is_br;
        end
    end

    always_comb begin
        for (int s = 0; s < slot_num; s++) begin
            if (upd_real_taken[s]) begin
                new_ctr[s] = (upd_meta_ctr[s] == 2'd3) ? 2'd3 : upd_meta_ctr[s] + 2'd1;
            end else begin
                new_ctr[s] = (upd_meta_ctr[s] == 2'd0) ? 2'd0 : upd_meta_ctr[s] - 2'd1;
            end
        end
    end

    assign alloc = update && !upd_hit;
    assign wr_way = upd_hit ? upd_way : victim_way;

    ubtb_replace i_replace (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .victim_way(victim_way)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            ctr_q <= '{default: '0};
        end else if (update) begin
            valid_q[wr_way] <= 1'b1;
            if (!(upd_br_carry || upd_tail_carry)) begin
                ctr_q[wr_way] <= new_ctr;  // carried slots keep their counters
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            tag_q[wr_way] <= upd_tag;
            br_en_q[wr_way] <= upd_br_en;
            br_offset_q[wr_way] <= upd_br_offset;
            br_target_q[wr_way] <= upd_br_target;
            br_tar_state_q[wr_way] <= upd_br_tar_state;
            br_carry_q[wr_way] <= upd_br_carry;
            tail_en_q[wr_way] <= upd_tail_en;
            tail_type_q[wr_way] <= upd_tail_type;
            tail_offset_q[wr_way] <= upd_tail_offset;
            tail_target_q[wr_way] <= upd_tail_target;
            tail_tar_state_q[wr_way] <= upd_tail_tar_state;
            tail_carry_q[wr_way] <= upd_tail_carry;
            fth_size_q[wr_way] <= upd_fth_size;
        end
    end

endmodule

// ==== ubtb_pred_stage.sv ====
module ubtb_pred_stage (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     pc_valid,
    input  logic                                     flush,
    input  logic                                     s2_redirect,
    input  logic                                     tage_ready,
    input  logic                                     lk_hit,
    input  logic                                     lk_taken,
    input  btb_types_pkg::br_type_e                  lk_br_type,
    input  logic [bpu_cfg_pkg::prediction_width-1:0] lk_size,
    input  logic [bpu_cfg_pkg::vaddr_size-1:0]       lk_target,
    input  logic [bpu_cfg_pkg::cond_cnt_w-1:0]       lk_cond_num,
    input  logic [bpu_cfg_pkg::slot_num-1:0]         lk_cond_valid,
    input  logic [bpu_cfg_pkg::slot_num-1:0]         lk_pred_taken,
    input  logic [bpu_cfg_pkg::slot_num-1:0][1:0]    lk_ctr,
    output logic                                     pred_en,
    output logic                                     pred_taken,
    output btb_types_pkg::br_type_e                  pred_branch_type,
    output logic [bpu_cfg_pkg::prediction_width-1:0] pred_size,
    output logic [bpu_cfg_pkg::vaddr_size-1:0]       pred_target,
    output logic [bpu_cfg_pkg::cond_cnt_w-1:0]       pred_cond_num,
    output logic [bpu_cfg_pkg::slot_num-1:0]         pred_cond_valid,
    output logic [bpu_cfg_pkg::slot_num-1:0]         pred_taken_bits,
    output logic [bpu_cfg_pkg::slot_num-1:0][1:0]    meta_ctr
);
    import btb_types_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_en <= 1'b0;
            pred_taken <= 1'b0;
            pred_branch_type <= condition;
            pred_size <= '0;
            pred_target <= '0;
            pred_cond_num <= '0;
            pred_cond_valid <= '0;
            pred_taken_bits <= '0;
            meta_ctr <= '0;
        end else begin
            pred_en <= pc_valid && tage_ready && !flush && !s2_redirect; // dropped, never retried
            pred_taken <= lk_hit && lk_taken;
            pred_branch_type <= lk_br_type;
            pred_size <= lk_size;
            pred_target <= lk_target;
            pred_cond_num <= lk_cond_num;
            pred_cond_valid <= lk_cond_valid;
            pred_taken_bits <= lk_hit ? lk_pred_taken : '0;
            meta_ctr <= lk_ctr;
        end
    end

endmodule

// ==== ubtb_top.sv ====
module ubtb_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [bpu_cfg_pkg::vaddr_size-1:0]       pc,
    input  logic                                     pc_valid,
    input  logic                                     flush,
    input  logic                                     s2_redirect,
    input  logic                                     tage_ready,
    input  logic                                     update,
    input  logic [bpu_cfg_pkg::vaddr_size-1:0]       upd_start_addr,
    input  logic                                     upd_br_en,
    input  logic [bpu_cfg_pkg::prediction_width-1:0] upd_br_offset,
    input  logic [bpu_cfg_pkg::jal_offset-1:0]       upd_br_target,
    input  btb_types_pkg::tar_state_e                upd_br_tar_state,
    input  logic                                     upd_br_carry,
    input  logic                                     upd_tail_en,
    input  btb_types_pkg::br_type_e                  upd_tail_type,
    input  logic [bpu_cfg_pkg::prediction_width-1:0] upd_tail_offset,
    input  logic [bpu_cfg_pkg::jalr_offset-1:0]      upd_tail_target,
    input  btb_types_pkg::tar_state_e                upd_tail_tar_state,
    input  logic                                     upd_tail_carry,
    input  logic [bpu_cfg_pkg::prediction_width-1:0] upd_fth_size,
    input  logic [bpu_cfg_pkg::slot_num-1:0][1:0]    upd_meta_ctr,
    input  logic [bpu_cfg_pkg::slot_num-1:0]         upd_real_taken,
    output logic                                     pred_en,
    output logic                                     pred_taken,
    output btb_types_pkg::br_type_e                  pred_branch_type,
    output logic [bpu_cfg_pkg::prediction_width-1:0] pred_size,
    output logic [bpu_cfg_pkg::vaddr_size-1:0]       pred_target,
    output logic [bpu_cfg_pkg::cond_cnt_w-1:0]       pred_cond_num,
    output logic [bpu_cfg_pkg::slot_num-1:0]         pred_cond_valid,
    output logic [bpu_cfg_pkg::slot_num-1:0]         pred_taken_bits,
    output logic [bpu_cfg_pkg::slot_num-1:0][1:0]    meta_ctr
);
    import bpu_cfg_pkg::*;
    import btb_types_pkg::*;

    logic                        lk_hit, lk_taken;
    br_type_e                    lk_br_type;
    logic [prediction_width-1:0] lk_size;
    logic [vaddr_size-1:0]       lk_target;
    logic [cond_cnt_w-1:0]       lk_cond_num;
    logic [slot_num-1:0]         lk_cond_valid, lk_pred_taken;
    logic [slot_num-1:0][1:0]    lk_ctr;

    ubtb i_ubtb (
        .clk(clk), .rst(rst), .pc(pc), .update(update),
        .upd_start_addr(upd_start_addr),
        .upd_br_en(upd_br_en), .upd_br_offset(upd_br_offset), .upd_br_target(upd_br_target),
        .upd_br_tar_state(upd_br_tar_state), .upd_br_carry(upd_br_carry),
        .upd_tail_en(upd_tail_en), .upd_tail_type(upd_tail_type),
        .upd_tail_offset(upd_tail_offset), .upd_tail_target(upd_tail_target),
        .upd_tail_tar_state(upd_tail_tar_state), .upd_tail_carry(upd_tail_carry),
        .upd_fth_size(upd_fth_size), .upd_meta_ctr(upd_meta_ctr),
        .upd_real_taken(upd_real_taken),
        .lk_hit(lk_hit), .lk_taken(lk_taken), .lk_br_type(lk_br_type), .lk_size(lk_size),
        .lk_target(lk_target), .lk_cond_num(lk_cond_num), .lk_cond_valid(lk_cond_valid),
        .lk_pred_taken(lk_pred_taken), .lk_ctr(lk_ctr)
    );

    ubtb_pred_stage i_pred_stage (
        .clk(clk), .rst(rst), .pc_valid(pc_valid), .flush(flush),
        .s2_redirect(s2_redirect), .tage_ready(tage_ready),
        .lk_hit(lk_hit), .lk_taken(lk_taken), .lk_br_type(lk_br_type), .lk_size(lk_size),
        .lk_target(lk_target), .lk_cond_num(lk_cond_num), .lk_cond_valid(lk_cond_valid),
        .lk_pred_taken(lk_pred_taken), .lk_ctr(lk_ctr),
        .pred_en(pred_en), .pred_taken(pred_taken), .pred_branch_type(pred_branch_type),
        .pred_size(pred_size), .pred_target(pred_target), .pred_cond_num(pred_cond_num),
        .pred_cond_valid(pred_cond_valid), .pred_taken_bits(pred_taken_bits),
        .meta_ctr(meta_ctr)
    );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released between edges so no flop sees it change at its own edge
    end

endmodule

// ==== ubtb_asserts.sv ====
module ubtb_asserts (
    input logic                                     clk, rst, pc_valid, flush, s2_redirect,
    input logic                                     tage_ready, lk_hit, pred_en, pred_taken,
    input logic                                     update,
    input logic [bpu_cfg_pkg::vaddr_size-1:0]       pc, pred_target, upd_start_addr,
    input logic [bpu_cfg_pkg::prediction_width-1:0] pred_size,
    input logic [bpu_cfg_pkg::cond_cnt_w-1:0]       pred_cond_num,
    input logic [bpu_cfg_pkg::slot_num-1:0]         pred_cond_valid, pred_taken_bits
);
    timeunit 1ns;
    timeprecision 1ps;
    import bpu_cfg_pkg::*;

    int err_cnt = 0;

    // a prediction is enabled only for a clean lookup one edge earlier
    a_gate: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> pred_en == $past(pc_valid && tage_ready && !flush && !s2_redirect))
    else begin
        err_cnt++;
        $error("pred_en does not follow the lookup gating of the previous edge");
    end

    a_miss: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && !$past(lk_hit) |-> pred_size == '1 && pred_cond_num == '0
            && pred_cond_valid == '0 && pred_taken_bits == '0
            && !pred_taken && pred_target == $past(pc) + 32'd32)
    else begin
        err_cnt++;
        $error("a missed lookup did not give the fall-through block prediction");
    end

    // an update written at one edge is already seen by the lookup of the next cycle
    a_upd_visible: assert property (@(posedge clk) disable iff (rst)
        $past(update) && (pc[block_off_w +: btb_tag_size]
            == $past(upd_start_addr[block_off_w +: btb_tag_size])) |-> lk_hit)
    else begin
        err_cnt++;
        $error("a lookup right after an update to its tag missed");
    end

endmodule

// ==== ubtb_tb.sv ====
module ubtb_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import bpu_cfg_pkg::*;
    import btb_types_pkg::*;

    localparam int max_cycles = 600;  // the tests need under 200 cycles after reset

    logic clk, rst;
    logic pc_valid = 1'b0, flush = 1'b0, s2_redirect = 1'b0, tage_ready = 1'b1, update = 1'b0;
    logic upd_br_en = 1'b0, upd_br_carry = 1'b0, upd_tail_en = 1'b0, upd_tail_carry = 1'b0;
    logic [vaddr_size-1:0] pc = '0, upd_start_addr = '0;
    logic [prediction_width-1:0] upd_br_offset = 4'd3, upd_tail_offset = 4'd5;
    logic [prediction_width-1:0] upd_fth_size = 4'd6;
    logic [jal_offset-1:0] upd_br_target = '0;
    logic [jalr_offset-1:0] upd_tail_target = '0;
    tar_state_e upd_br_tar_state = tar_norm, upd_tail_tar_state = tar_norm;
    br_type_e upd_tail_type = direct;
    logic [slot_num-1:0][1:0] upd_meta_ctr = '0;
    logic [slot_num-1:0] upd_real_taken = '0;
    logic pred_en, pred_taken;
    br_type_e pred_branch_type;
    logic [prediction_width-1:0] pred_size;
    logic [vaddr_size-1:0] pred_target;
    logic [cond_cnt_w-1:0] pred_cond_num;
    logic [slot_num-1:0] pred_cond_valid, pred_taken_bits;
    logic [slot_num-1:0][1:0] meta_ctr;

    logic [31:0] rng_state = 32'd42;
    logic [31:0] pa, pb;
    logic [11:0] hits_before, hits_after;
    int errors = 0;
    int cycles = 0;

    tb_clock_gen i_clk_gen (.clk(clk), .rst(rst));

    ubtb_top i_ubtb_top (.*);

    bind ubtb_top ubtb_asserts i_asserts (
        .clk(clk), .rst(rst), .pc_valid(pc_valid), .flush(flush), .s2_redirect(s2_redirect),
        .tage_ready(tage_ready), .lk_hit(lk_hit), .pred_en(pred_en), .pred_taken(pred_taken),
        .update(update), .pc(pc), .pred_target(pred_target),
        .upd_start_addr(upd_start_addr), .pred_size(pred_size),
        .pred_cond_num(pred_cond_num), .pred_cond_valid(pred_cond_valid),
        .pred_taken_bits(pred_taken_bits)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // high part of the fetch address moved by the target state, then the stored halfword bits
    function automatic logic [31:0] expect_target(logic [31:0] base, logic [31:0] low,
                                                  int low_w, tar_state_e st);
        logic [31:0] high;
        high = base >> (low_w + 1);
        if (st == tar_ov) high = high + 32'd1;
        if (st == tar_un) high = high - 32'd1;
        return (high << (low_w + 1)) | (low << 1);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic write_entry(input logic [31:0] addr, input logic br_en, input logic tail_en,
                               input tar_state_e st, input logic carry, input logic [1:0] ctr,
                               input logic taken);
        @(posedge clk);
        update <= 1'b1;
        upd_start_addr <= addr;
        upd_br_en <= br_en;
        upd_tail_en <= tail_en;
        upd_br_tar_state <= st;
        upd_tail_tar_state <= st;
        upd_br_carry <= carry;
        upd_br_target <= jal_offset'(next_rand());
        upd_tail_target <= jalr_offset'(next_rand());
        upd_meta_ctr <= {2'd0, ctr};
        upd_real_taken <= {1'b0, taken};
        @(posedge clk);
        update <= 1'b0;
    endtask

    task automatic lookup(input logic [31:0] addr);
        @(posedge clk);
        pc <= addr;
        pc_valid <= 1'b1;
        @(posedge clk);
        pc_valid <= 1'b0;
        @(negedge clk);  // registered prediction is stable here
    endtask

    initial begin
        @(negedge rst);
        check("reset_pred_en", 32'd0, 32'(pred_en));
        pa = next_rand();
        lookup(pa);
        check("miss_target", pa + 32'd32, pred_target);
        check("miss_size", 32'hf, 32'(pred_size));

        for (int s = 0; s < 3; s++) begin
            write_entry(pa, 1'b0, 1'b1, tar_state_e'(s), 1'b0, 2'd0, 1'b0);
            lookup(pa);
            check("tail_taken", 32'd1, 32'(pred_taken));
            check("tail_type", 32'(direct), 32'(pred_branch_type));
            check("tail_target", expect_target(pa, 32'(upd_tail_target), jalr_offset,
                                               tar_state_e'(s)), pred_target);
            check("tail_cond_num", 32'd0, 32'(pred_cond_num));
            check("tail_cond_valid", 32'd0, 32'(pred_cond_valid));
        end

        pb = next_rand();
        write_entry(pb, 1'b1, 1'b0, tar_norm, 1'b0, 2'd1, 1'b1);  // counter 1 moves up to 2
        lookup(pb);
        check("cond_ctr_up", 32'd2, 32'(meta_ctr[0]));
        check("cond_taken", 32'd1, 32'(pred_taken));
        check("cond_type", 32'(condition), 32'(pred_branch_type));
        check("cond_size", 32'd3, 32'(pred_size));
        check("cond_target", expect_target(pb, 32'(upd_br_target), jal_offset, tar_norm),
              pred_target);
        check("cond_num", 32'd1, 32'(pred_cond_num));
        check("cond_valid", 32'd1, 32'(pred_cond_valid));
        check("cond_taken_bits", 32'd1, 32'(pred_taken_bits));
        write_entry(pb, 1'b1, 1'b0, tar_norm, 1'b0, 2'd2, 1'b0);  // counter 2 moves down to 1
        lookup(pb);
        check("cond_not_taken", pb + 32'd6, pred_target);
        check("cond_not_taken_flag", 32'd0, 32'(pred_taken));
        check("cond_not_taken_bits", 32'd0, 32'(pred_taken_bits));
        write_entry(pb, 1'b1, 1'b0, tar_norm, 1'b1, 2'd3, 1'b1);
        lookup(pb);
        check("carry_ctr_kept", 32'd1, 32'(meta_ctr[0]));
        check("carry_taken", 32'd1, 32'(pred_taken));
        write_entry(pb, 1'b1, 1'b0, tar_norm, 1'b0, 2'd3, 1'b1);
        lookup(pb);
        check("ctr_sat_high", 32'd3, 32'(meta_ctr[0]));
        write_entry(pb, 1'b1, 1'b0, tar_norm, 1'b0, 2'd0, 1'b0);
        lookup(pb);
        check("ctr_sat_low", 32'd0, 32'(meta_ctr[0]));

        repeat (12) begin
            @(posedge clk);
            {pc_valid, flush, s2_redirect, tage_ready} <= 4'(next_rand());
        end
        @(posedge clk);
        {pc_valid, flush, s2_redirect, tage_ready} <= 4'b0001;

        // twelve distinct tags overflow the eight ways
        for (int i = 0; i < 12; i++) begin
            write_entry(32'h8000_0000 + 32'(i << 5), 1'b0, 1'b1, tar_norm, 1'b0, 2'd0, 1'b0);
        end
        for (int i = 0; i < 12; i++) begin
            lookup(32'h8000_0000 + 32'(i << 5));
            hits_before[i] = pred_taken;
        end
        check("evict_resident_max", 32'd1, 32'($countones(hits_before) <= 8));
        check("last_resident", 32'd1, 32'(hits_before[11]));
        write_entry(32'h8000_0160, 1'b0, 1'b1, tar_ov, 1'b0, 2'd0, 1'b0);
        for (int i = 0; i < 12; i++) begin
            lookup(32'h8000_0000 + 32'(i << 5));
            hits_after[i] = pred_taken;
        end
        check("rewrite_same_way", 32'(hits_before), 32'(hits_after));

        $display("check errors: %0d, assertion errors: %0d", errors,
                 i_ubtb_top.i_asserts.err_cnt);
        if (errors == 0 && i_ubtb_top.i_asserts.err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
bpu_cfg_pkg.sv
btb_types_pkg.sv
ubtb_replace.sv
btb_target_calc.sv
ubtb.sv
ubtb_pred_stage.sv
ubtb_top.sv
tb_clock_gen.sv
ubtb_asserts.sv
ubtb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the micro BTB testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module ubtb_tb \
    -f list.f -o ubtb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ubtb_sim +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
